/* filelist.f */
logic/video_pkg.sv
logic/key_toggle.sv
logic/pixel_delay.sv
logic/async_pixel_fifo.sv
logic/cam_switch.sv
testbench/cam_switch_checker.sv
testbench/tb_cam_switch.sv

/* logic/async_pixel_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module async_pixel_fifo (
    input  logic            i_wr_clk,
    input  logic            i_wr_rst,
    input  logic            i_wr_en,
    input  video_pkg::rgb_t i_wr_data,
    output logic            o_wr_full,
    input  logic            main_clk,
    input  logic            rstn,
    input  logic            i_rd_rst,
    input  logic            i_rd_en,
    output video_pkg::rgb_t o_rd_data,
    output logic            o_rd_empty
);
    import video_pkg::*;

    rgb_t mem [FIFO_DEPTH];

    logic [FIFO_AW:0] wr_bin;
    logic [FIFO_AW:0] wr_bin_nxt;
    logic [FIFO_AW:0] wr_gray;
    logic [FIFO_AW:0] rd_gray_wq1;
    logic [FIFO_AW:0] rd_gray_wq2;
    logic             wr_push;

    logic [FIFO_AW:0] rd_bin;
    logic [FIFO_AW:0] rd_bin_nxt;
    logic [FIFO_AW:0] rd_gray;
    logic [FIFO_AW:0] wr_gray_rq1;
    logic [FIFO_AW:0] wr_gray_rq2;
    logic             rd_pop;
    rgb_t             rd_stage;

    function automatic logic [FIFO_AW:0] bin2gray(input logic [FIFO_AW:0] bin);
        return bin ^ (bin >> 1);
    endfunction

    // Write domain
    assign wr_push    = i_wr_en && !i_wr_rst && !o_wr_full;
    assign wr_bin_nxt = wr_bin + 1'b1;
    assign o_wr_full  = (wr_gray == {~rd_gray_wq2[FIFO_AW:FIFO_AW-1],
                                     rd_gray_wq2[FIFO_AW-2:0]});

    always_ff @(posedge i_wr_clk or negedge rstn) begin
        if (!rstn) begin
            wr_bin  <= '0;
            wr_gray <= '0;
        end else if (i_wr_rst) begin
            wr_bin  <= '0;     // Restart at minor frame start
            wr_gray <= '0;
        end else if (wr_push) begin
            wr_bin  <= wr_bin_nxt;
            wr_gray <= bin2gray(wr_bin_nxt);
        end
    end

    always_ff @(posedge i_wr_clk or negedge rstn) begin
        if (!rstn) begin
            rd_gray_wq1 <= '0;
            rd_gray_wq2 <= '0;
        end else begin
            rd_gray_wq1 <= rd_gray;
            rd_gray_wq2 <= rd_gray_wq1;
        end
    end

    always_ff @(posedge i_wr_clk) begin
        if (wr_push) begin
            mem[wr_bin[FIFO_AW-1:0]] <= i_wr_data;
        end
    end

    // Read domain
    assign rd_pop     = i_rd_en && !i_rd_rst && !o_rd_empty;
    assign rd_bin_nxt = rd_bin + 1'b1;
    assign o_rd_empty = (rd_gray == wr_gray_rq2);

    always_ff @(posedge main_clk or negedge rstn) begin
        if (!rstn) begin
            rd_bin  <= '0;
            rd_gray <= '0;
        end else if (i_rd_rst) begin
            rd_bin  <= '0;     // Restart at main frame start
            rd_gray <= '0;
        end else if (rd_pop) begin
            rd_bin  <= rd_bin_nxt;
            rd_gray <= bin2gray(rd_bin_nxt);
        end
    end

    always_ff @(posedge main_clk or negedge rstn) begin
        if (!rstn) begin
            wr_gray_rq1 <= '0;
            wr_gray_rq2 <= '0;
        end else begin
            wr_gray_rq1 <= wr_gray;
            wr_gray_rq2 <= wr_gray_rq1;
        end
    end

    // Two register stages on read data
    always_ff @(posedge main_clk or negedge rstn) begin
        if (!rstn) begin
            rd_stage  <= '0;
            o_rd_data <= '0;
        end else begin
            if (rd_pop) begin
                rd_stage <= mem[rd_bin[FIFO_AW-1:0]];
            end
            o_rd_data <= rd_stage;
        end
    end

endmodule : async_pixel_fifo

`default_nettype wire

/* logic/cam_switch.sv */
`timescale 1ns/1ns
`default_nettype none

module cam_switch (
    input  logic                    main_clk,
    input  logic                    rstn,
    input  logic                    i_minor_clk,
    input  video_pkg::video_pixel_t i_main_pix,
    input  video_pkg::video_pixel_t i_minor_pix,
    input  logic                    i_key,
    output logic                    o_cam_id,
    output video_pkg::video_pixel_t o_pix
);
    import video_pkg::*;

    logic         key_sel;
    logic         main_vsync_d;
    logic         minor_sel;
    video_pixel_t main_dly;
    logic         rd_en_early;
    logic         fifo_wr_rst;
    logic         fifo_wr_en;
    logic         fifo_rd_rst;
    logic         fifo_rd_en;
    rgb_t         fifo_rgb;

    key_toggle u_key_toggle (
        .main_clk (main_clk),
        .rstn     (rstn),
        .i_key    (i_key),
        .o_sel    (key_sel)
    );

    // Selection follows the key only at a main frame boundary
    always_ff @(posedge main_clk or negedge rstn) begin
        if (!rstn) begin
            main_vsync_d <= 1'b0;
            o_cam_id     <= MAIN_CAM_ID;
        end else begin
            main_vsync_d <= i_main_pix.vsync;
            if (main_vsync_d && i_main_pix.vsync) begin
                o_cam_id <= key_sel;
            end
        end
    end

    assign minor_sel = (o_cam_id != MAIN_CAM_ID);

    // Main timing and RGB at full latency
    pixel_delay #(
        .T     (video_pixel_t),
        .DEPTH (PIPE_DELAY)
    ) u_main_delay (
        .main_clk (main_clk),
        .rstn     (rstn),
        .i_data   (i_main_pix),
        .o_data   (main_dly)
    );

    // Early read strobe leads o_pix.de by the FIFO latency
    pixel_delay #(
        .T     (logic),
        .DEPTH (PIPE_DELAY - MINOR_OFFSET)
    ) u_rd_en_delay (
        .main_clk (main_clk),
        .rstn     (rstn),
        .i_data   (i_main_pix.de),
        .o_data   (rd_en_early)
    );

    // FIFO parked in reset while main camera is shown
    assign fifo_wr_rst = minor_sel ? i_minor_pix.vsync : 1'b1;
    assign fifo_wr_en  = minor_sel ? i_minor_pix.de    : 1'b0;
    assign fifo_rd_rst = minor_sel ? i_main_pix.vsync  : 1'b1;
    assign fifo_rd_en  = minor_sel ? rd_en_early       : 1'b0;

    async_pixel_fifo u_minor_fifo (
        .i_wr_clk   (i_minor_clk),
        .i_wr_rst   (fifo_wr_rst),
        .i_wr_en    (fifo_wr_en),
        .i_wr_data  (i_minor_pix.rgb),
        .o_wr_full  (),
        .main_clk   (main_clk),
        .rstn       (rstn),
        .i_rd_rst   (fifo_rd_rst),
        .i_rd_en    (fifo_rd_en),
        .o_rd_data  (fifo_rgb),
        .o_rd_empty ()
    );

    always_comb begin
        o_pix = main_dly;
        if (minor_sel) begin
            o_pix.rgb = fifo_rgb;     // Minor pixels on main timing
        end
    end

endmodule : cam_switch

`default_nettype wire

/* logic/key_toggle.sv */
`timescale 1ns/1ns
`default_nettype none

module key_toggle (
    input  logic main_clk,
    input  logic rstn,
    input  logic i_key,
    output logic o_sel
);
    import video_pkg::*;

    logic                 key_meta;
    logic                 key_sync;
    logic                 key_lvl;     // Accepted level
    logic                 key_lvl_d;
    logic [DEB_CNT_W-1:0] deb_cnt;

    always_ff @(posedge main_clk or negedge rstn) begin
        if (!rstn) begin
            key_meta <= 1'b0;
            key_sync <= 1'b0;
        end else begin
            key_meta <= i_key;
            key_sync <= key_meta;
        end
    end

    // Count consecutive samples that differ from the accepted level
    always_ff @(posedge main_clk or negedge rstn) begin
        if (!rstn) begin
            deb_cnt <= '0;
            key_lvl <= 1'b0;
        end else if (key_sync == key_lvl) begin
            deb_cnt <= '0;     // Glitch over so the count restarts
        end else if (deb_cnt == DEB_CNT_W'(DEBOUNCE_TICKS - 1)) begin
            deb_cnt <= '0;
            key_lvl <= key_sync;
        end else begin
            deb_cnt <= deb_cnt + 1'b1;
        end
    end

    always_ff @(posedge main_clk or negedge rstn) begin
        if (!rstn) begin
            key_lvl_d <= 1'b0;
            o_sel     <= MAIN_CAM_ID;
        end else begin
            key_lvl_d <= key_lvl;
            if (key_lvl && !key_lvl_d) begin
                o_sel <= ~o_sel;     // Press accepted
            end
        end
    end

endmodule : key_toggle

`default_nettype wire

/* logic/pixel_delay.sv */
`timescale 1ns/1ns
`default_nettype none

module pixel_delay #(
    parameter type T     = video_pkg::video_pixel_t,
    parameter int  DEPTH = video_pkg::PIPE_DELAY
) (
    input  logic main_clk,
    input  logic rstn,
    input  T     i_data,
    output T     o_data
);

    T pipe [DEPTH];

    always_ff @(posedge main_clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < DEPTH; i++) begin
                pipe[i] <= '0;
            end
        end else begin
            pipe[0] <= i_data;
            for (int i = 1; i < DEPTH; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign o_data = pipe[DEPTH-1];     // DEPTH cycles after input

endmodule : pixel_delay

`default_nettype wire

/* logic/video_pkg.sv */
`default_nettype none

package video_pkg;

    // Largest active picture sets the coordinate widths
    localparam int H_ACT = 1280;
    localparam int V_ACT = 720;
    localparam int X_W   = $clog2(H_ACT);
    localparam int Y_W   = $clog2(V_ACT);

    // Main path latency and FIFO read latency
    localparam int PIPE_DELAY   = 5;
    localparam int MINOR_OFFSET = 2;

    // Key debounce
    localparam int DEBOUNCE_TICKS = 5;
    localparam int DEB_CNT_W      = $clog2(DEBOUNCE_TICKS + 1);

    // Clock-crossing FIFO
    localparam int FIFO_AW    = 4;
    localparam int FIFO_DEPTH = 1 << FIFO_AW;

    localparam logic MAIN_CAM_ID = 1'b0;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    typedef struct packed {
        logic           hsync;
        logic           vsync;
        logic           de;
        rgb_t           rgb;
        logic [X_W-1:0] x;
        logic [Y_W-1:0] y;
    } video_pixel_t;

endpackage : video_pkg

`default_nettype wire

/* testbench/cam_switch_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module cam_switch_checker (
    input  logic                    main_clk,
    input  logic                    rstn,
    input  video_pkg::video_pixel_t i_main_pix,
    input  video_pkg::video_pixel_t o_pix,
    input  logic                    o_cam_id
);
    import video_pkg::*;

    int fail_cnt = 0;
    int cyc;     // Cycles since reset release

    always_ff @(posedge main_clk or negedge rstn) begin
        if (!rstn) begin
            cyc <= 0;
        end else if (cyc < 1000) begin
            cyc <= cyc + 1;
        end
    end

    // Output timing is the main input delayed by PIPE_DELAY
    timing_follows_main: assert property (@(posedge main_clk) disable iff (!rstn)
        cyc >= PIPE_DELAY |->
            {o_pix.hsync, o_pix.vsync, o_pix.de, o_pix.x, o_pix.y} ==
            $past({i_main_pix.hsync, i_main_pix.vsync, i_main_pix.de,
                   i_main_pix.x, i_main_pix.y}, PIPE_DELAY))
        else begin
            fail_cnt++;
            $error("o_pix timing differs from delayed main input");
        end

    main_rgb_passes: assert property (@(posedge main_clk) disable iff (!rstn)
        (cyc >= PIPE_DELAY && o_cam_id == MAIN_CAM_ID && o_pix.de) |->
            o_pix.rgb == $past(i_main_pix.rgb, PIPE_DELAY))
        else begin
            fail_cnt++;
            $error("o_pix.rgb differs from delayed main rgb");
        end

    // Selection moves only inside main vsync
    switch_at_vsync: assert property (@(posedge main_clk) disable iff (!rstn)
        (cyc >= 2 && $changed(o_cam_id)) |->
            ($past(i_main_pix.vsync, 1) && $past(i_main_pix.vsync, 2)))
        else begin
            fail_cnt++;
            $error("o_cam_id changed outside a main frame boundary");
        end

endmodule : cam_switch_checker

bind cam_switch cam_switch_checker u_checker (
    .main_clk   (main_clk),
    .rstn       (rstn),
    .i_main_pix (i_main_pix),
    .o_pix      (o_pix),
    .o_cam_id   (o_cam_id)
);

`default_nettype wire

/* testbench/tb_cam_switch.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_cam_switch;
    import video_pkg::*;

    localparam int FRAME_W      = 16;
    localparam int FRAME_H      = 4;
    localparam int MAIN_PERIOD  = 40;
    localparam int MINOR_PERIOD = 30;
    localparam int TIMEOUT_CYC  = 2000;

    logic         main_clk;
    logic         minor_clk;
    logic         rstn;
    logic         key;
    video_pixel_t main_pix;
    video_pixel_t minor_pix;
    video_pixel_t o_pix;
    logic         o_cam_id;

    int   errors;
    int   main_frames;
    int   minor_checked;
    int   out_idx;
    int   minor_cmds [$];     // 0 starts a minor frame, 1 a minor line
    logic prev_out_vsync;

    initial begin
        main_clk = 1'b0;
        forever #(MAIN_PERIOD / 2) main_clk = ~main_clk;
    end

    initial begin
        minor_clk = 1'b0;
        forever #(MINOR_PERIOD / 2) minor_clk = ~minor_clk;
    end

    cam_switch u_cam_switch (
        .main_clk    (main_clk),
        .rstn        (rstn),
        .i_minor_clk (minor_clk),
        .i_main_pix  (main_pix),
        .i_minor_pix (minor_pix),
        .i_key       (key),
        .o_cam_id    (o_cam_id),
        .o_pix       (o_pix)
    );

    task automatic drive_main(input logic hs, input logic vs, input logic de,
                              input int x, input int y);
        @(negedge main_clk);
        main_pix       = '0;
        main_pix.hsync = hs;
        main_pix.vsync = vs;
        main_pix.de    = de;
        if (de) begin
            main_pix.rgb.r = 8'hA0;
            main_pix.rgb.g = 8'(x);
            main_pix.rgb.b = 8'(y);
            main_pix.x     = X_W'(x);
            main_pix.y     = Y_W'(y);
        end
    endtask

    task automatic main_frame();
        int porch;
        minor_cmds.push_back(0);     // Minor frame a few cycles early
        repeat (3) drive_main(0, 0, 0, 0, 0);
        repeat (3) drive_main(0, 1, 0, 0, 0);
        repeat (2) drive_main(0, 0, 0, 0, 0);
        for (int y = 0; y < FRAME_H; y++) begin
            minor_cmds.push_back(1);
            repeat (4) drive_main(0, 0, 0, 0, 0);
            for (int x = 0; x < FRAME_W; x++) begin
                drive_main(0, 0, 1, x, y);
            end
            porch = 2 + ($urandom % 4);
            repeat (2) drive_main(1, 0, 0, 0, 0);
            repeat (porch) drive_main(0, 0, 0, 0, 0);
        end
        porch = 6 + ($urandom % 4);     // Lets the pipeline drain
        repeat (porch) drive_main(0, 0, 0, 0, 0);
        main_frames++;
    endtask

    task automatic minor_run();
        int idx;
        int cmd;
        idx = 0;
        forever begin
            @(negedge minor_clk);
            minor_pix = '0;
            if (minor_cmds.size() != 0) begin
                cmd = minor_cmds.pop_front();
                if (cmd == 0) begin
                    idx             = 0;
                    minor_pix.vsync = 1'b1;
                    @(negedge minor_clk);
                end else begin
                    for (int i = 0; i < FRAME_W; i++) begin
                        if (i > 0) begin
                            @(negedge minor_clk);
                        end
                        minor_pix.de  = 1'b1;
                        minor_pix.rgb = {8'h05, 16'(idx)};
                        minor_pix.x   = X_W'(i);
                        idx++;
                    end
                end
            end
        end
    endtask

    // Minor pixels in order during each delayed frame
    always @(negedge main_clk) begin : minor_order
        rgb_t exp;
        if (rstn) begin
            if (o_pix.vsync && !prev_out_vsync) begin
                out_idx = 0;
            end
            prev_out_vsync = o_pix.vsync;
            if (o_pix.de && o_cam_id != MAIN_CAM_ID) begin
                exp = {8'h05, 16'(out_idx)};
                assert (o_pix.rgb == exp) else begin
                    errors++;
                    $display("Mismatch o_pix.rgb: got %h expected %h", o_pix.rgb, exp);
                end
                out_idx++;
                minor_checked++;
            end
        end
    end

    task automatic check_after_reset();
        repeat (PIPE_DELAY) begin
            @(negedge main_clk);
            assert (o_cam_id == MAIN_CAM_ID) else begin
                errors++;
                $display("Mismatch o_cam_id: got %h expected %h", o_cam_id, MAIN_CAM_ID);
            end
            assert ({o_pix.de, o_pix.hsync, o_pix.vsync} == 3'b000) else begin
                errors++;
                $display("Mismatch o_pix de/hsync/vsync: got %h expected %h",
                         {o_pix.de, o_pix.hsync, o_pix.vsync}, 3'h0);
            end
        end
    endtask

    task automatic press_key(input int cycles);
        @(negedge main_clk);
        key = 1'b1;
        repeat (cycles) @(negedge main_clk);
        key = 1'b0;
    endtask

    task automatic wait_cam_id(input logic val);
        int n;
        n = 0;
        while (o_cam_id !== val && n < TIMEOUT_CYC) begin
            @(negedge main_clk);
            n++;
        end
        if (o_cam_id !== val) begin
            errors++;
            $display("Timeout while waiting for the camera selection to change to %0h", val);
        end
    endtask

    task automatic wait_frames(input int count);
        int target;
        int n;
        target = main_frames + count;
        n      = 0;
        while (main_frames < target && n < TIMEOUT_CYC * count) begin
            @(negedge main_clk);
            n++;
        end
        if (main_frames < target) begin
            errors++;
            $display("Timeout while waiting for %0d main frames", count);
        end
    endtask

    initial begin
        #(MAIN_PERIOD * 50000);
        $display("Simulation limit reached before the test sequence finished");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        rstn           = 1'b0;
        key            = 1'b0;
        main_pix       = '0;
        minor_pix      = '0;
        errors         = 0;
        main_frames    = 0;
        minor_checked  = 0;
        out_idx        = 0;
        prev_out_vsync = 1'b0;
        void'($urandom(12));
        repeat (2) @(negedge main_clk);
        rstn = 1'b1;

        fork
            forever main_frame();
            minor_run();
        join_none

        check_after_reset();
        wait_frames(2);

        press_key(2);     // Glitch below debounce length
        wait_frames(2);
        assert (o_cam_id == MAIN_CAM_ID) else begin
            errors++;
            $display("Mismatch o_cam_id after glitch: got %h expected %h",
                     o_cam_id, MAIN_CAM_ID);
        end

        press_key(20);
        wait_cam_id(~MAIN_CAM_ID);
        wait_frames(3);
        assert (minor_checked >= 2 * FRAME_W * FRAME_H) else begin
            errors++;
            $display("Too few minor pixels reached the output: %0d", minor_checked);
        end

        press_key(20);
        wait_cam_id(MAIN_CAM_ID);
        wait_frames(2);

        $display("Errors: checks=%0d assertions=%0d", errors, u_cam_switch.u_checker.fail_cnt);
        if (errors == 0 && u_cam_switch.u_checker.fail_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule : tb_cam_switch

`default_nettype wire
